// ==== rtl/la_consts.svh ====
`ifndef LA_CONSTS_SVH
`define LA_CONSTS_SVH

// one sample of the digital inputs
`define LA_SAMPLE_W         8

// stored word, four samples with the oldest in the top byte
`define LA_WORD_W           32
`define LA_SAMPLES_PER_WORD 4

// log2 of the FIFO depth, 64 words
`define LA_FIFO_AW          6

`endif

// ==== rtl/la_pkg.sv ====
`include "la_consts.svh"

package la_pkg;

    typedef logic [`LA_SAMPLE_W-1:0] sample_t;
    typedef logic [`LA_WORD_W-1:0]   word_t;
    typedef logic [31:0]             count_t;

    typedef enum logic [2:0] {
        CAP_IDLE    = 3'd0,
        CAP_PRELOAD = 3'd1,  // filling the pre-trigger ring
        CAP_WAIT    = 3'd2,  // ring full, waiting for the trigger
        CAP_CAPTURE = 3'd3,
        CAP_READ    = 3'd4,  // capture complete, draining
        CAP_DONE    = 3'd5
    } capture_state_e;

    // both counts are in words, 1 <= pre_words < total_words
    typedef struct packed {
        count_t pre_words;
        count_t total_words;
    } capture_cfg_t;

    typedef struct packed {
        sample_t mask;
        sample_t pattern;
    } trig_cfg_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } packed_word_t;

endpackage

// ==== rtl/la_fifo.sv ====
`timescale 1ns/1ps
`include "la_consts.svh"

module la_fifo (
    input  logic          clk,
    input  logic          rstn,
    input  logic          wr_en,
    input  la_pkg::word_t wr_data,
    input  logic          rd_en,
    output la_pkg::word_t rd_data,
    output logic          full,
    output logic          empty
);
    import la_pkg::*;

    localparam int AW    = `LA_FIFO_AW;
    localparam int DEPTH = 1 << AW;

    word_t       mem [DEPTH];
    logic [AW:0] wr_ptr;  // top bit counts laps of the memory
    logic [AW:0] rd_ptr;
    logic        do_wr;
    logic        do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // head word is always on the output, so a read just advances the pointer
    assign rd_data = mem[rd_ptr[AW-1:0]];

    // same slot on different laps means full
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

endmodule

// ==== rtl/la_trigger.sv ====
`timescale 1ns/1ps

module la_trigger (
    input  logic              clk,
    input  logic              rstn,
    input  la_pkg::sample_t   digital_in,
    input  la_pkg::trig_cfg_t cfg,
    input  logic              arm,
    output logic              trig
);
    import la_pkg::*;

    sample_t masked_in;
    sample_t masked_pattern;
    logic    match;
    logic    fired;

    // bits outside the mask never take part in the compare
    assign masked_in      = digital_in & cfg.mask;
    assign masked_pattern = cfg.pattern & cfg.mask;
    assign match          = (masked_in == masked_pattern);

    // --------------------------------------------------
    // registered fire, once per arming
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            trig  <= 1'b0;
            fired <= 1'b0;
        end else if (!arm) begin
            trig  <= 1'b0;
            fired <= 1'b0;  // a new arming starts here
        end else begin
            trig <= match && !fired;
            if (match) begin
                fired <= 1'b1;  // a pattern that holds on must not fire again
            end
        end
    end

endmodule

// ==== rtl/la_sample_packer.sv ====
`timescale 1ns/1ps
`include "la_consts.svh"

module la_sample_packer (
    input  logic                 clk,
    input  logic                 rstn,
    input  la_pkg::sample_t      digital_in,
    input  logic                 enable,
    output la_pkg::packed_word_t word
);
    import la_pkg::*;

    localparam int PHASE_W = $clog2(`LA_SAMPLES_PER_WORD + 1);
    localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`LA_SAMPLES_PER_WORD);

    logic [PHASE_W-1:0] phase;  // samples held in the shift register
    word_t              shift_reg;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase     <= '0;
            shift_reg <= '0;
        end else if (enable) begin
            if (phase == PHASE_LAST) begin
                phase <= PHASE_W'(1);  // the sample taken now opens the next word
            end else begin
                phase <= phase + PHASE_W'(1);
            end
            shift_reg <= {shift_reg[`LA_WORD_W-`LA_SAMPLE_W-1:0], digital_in};
        end else begin
            // the next enable starts on a fresh word
            phase     <= '0;
            shift_reg <= '0;
        end
    end

    // the oldest sample has shifted up into the top byte by now
    assign word.valid = (phase == PHASE_LAST);
    assign word.data  = shift_reg;

endmodule

// ==== rtl/la_datastore.sv ====
`timescale 1ns/1ps

module la_datastore (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 start,
    input  logic                 trig,
    input  la_pkg::capture_cfg_t cfg,
    input  la_pkg::packed_word_t word,
    output logic                 armed,
    output logic                 trig_arm,
    output logic                 busy,
    output logic                 done,
    output logic                 overflow,
    output logic                 rd_data_ready,
    input  logic                 rd_data_valid,
    output la_pkg::word_t        rd_data
);
    import la_pkg::*;

    capture_state_e state;
    capture_state_e next_state;
    count_t         load_cnt;    // words stored in preload and capture
    count_t         unload_cnt;  // words handed to the reader
    logic           accept_start;
    logic           reading;
    logic           wr_req;
    logic           fifo_rd_en;
    logic           fifo_full;
    logic           fifo_empty;
    logic           rd_fire;
    logic           last_pre;
    logic           last_cap;
    logic           last_read;

    assign accept_start = start && ((state == CAP_IDLE) || (state == CAP_DONE));
    assign reading      = (state == CAP_CAPTURE) || (state == CAP_READ);
    assign rd_fire      = rd_data_ready && rd_data_valid;

    assign last_pre  = word.valid && (load_cnt + 1 >= cfg.pre_words);
    assign last_cap  = word.valid && (load_cnt + 1 >= cfg.total_words);
    assign last_read = rd_fire && (unload_cnt + 1 >= cfg.total_words);

    // --------------------------------------------------
    // capture state machine
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= CAP_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            CAP_IDLE:    if (start) next_state = CAP_PRELOAD;
            CAP_PRELOAD: if (last_pre) next_state = CAP_WAIT;
            CAP_WAIT:    if (trig) next_state = CAP_CAPTURE;
            CAP_CAPTURE: if (last_cap) next_state = CAP_READ;
            // an empty FIFO here means dropped words shortened the stream
            CAP_READ:    if (last_read || fifo_empty) next_state = CAP_DONE;
            CAP_DONE:    if (start) next_state = CAP_PRELOAD;
            default:     next_state = CAP_IDLE;
        endcase
    end

    // --------------------------------------------------
    // counters and overflow
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_cnt   <= '0;
            unload_cnt <= '0;
            overflow   <= 1'b0;
        end else if (accept_start) begin
            load_cnt   <= '0;
            unload_cnt <= '0;
            overflow   <= 1'b0;
        end else begin
            // the count holds in the wait phase, the ring size stays fixed there
            if (word.valid && ((state == CAP_PRELOAD) || (state == CAP_CAPTURE))) begin
                load_cnt <= load_cnt + 1;
            end
            if (rd_fire) begin
                unload_cnt <= unload_cnt + 1;
            end
            if (wr_req && fifo_full) begin
                overflow <= 1'b1;  // word lost, sticky until the next start
            end
        end
    end

    // --------------------------------------------------
    // FIFO control and read port
    // --------------------------------------------------
    assign armed    = (state == CAP_PRELOAD) || (state == CAP_WAIT) || (state == CAP_CAPTURE);
    assign trig_arm = (state == CAP_WAIT);
    assign wr_req   = word.valid && armed;

    // in the wait phase the oldest word leaves as each new one comes in
    assign fifo_rd_en = ((state == CAP_WAIT) && word.valid) || rd_fire;

    assign rd_data_ready = reading && !fifo_empty;
    assign busy          = reading;
    assign done          = (state == CAP_DONE);

    la_fifo u_la_fifo (
        .clk     (clk),
        .rstn    (rstn),
        .wr_en   (wr_req),
        .wr_data (word.data),
        .rd_en   (fifo_rd_en),
        .rd_data (rd_data),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

endmodule

// ==== rtl/la_top.sv ====
`timescale 1ns/1ps

module la_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  la_pkg::sample_t      digital_in,
    input  la_pkg::trig_cfg_t    trig_cfg,
    input  la_pkg::capture_cfg_t cap_cfg,
    input  logic                 start,
    output logic                 busy,
    output logic                 done,
    output logic                 overflow,
    output logic                 rd_data_ready,
    input  logic                 rd_data_valid,
    output la_pkg::word_t        rd_data
);
    import la_pkg::*;

    logic         armed;     // packer runs through preload, wait and capture
    logic         trig_arm;  // trigger listens only while waiting
    logic         trig;
    packed_word_t word;

    // --------------------------------------------------
    // sampling front end
    // --------------------------------------------------
    la_trigger u_la_trigger (
        .clk        (clk),
        .rstn       (rstn),
        .digital_in (digital_in),
        .cfg        (trig_cfg),
        .arm        (trig_arm),
        .trig       (trig)
    );

    la_sample_packer u_la_sample_packer (
        .clk        (clk),
        .rstn       (rstn),
        .digital_in (digital_in),
        .enable     (armed),
        .word       (word)
    );

    // --------------------------------------------------
    // store and read port
    // --------------------------------------------------
    la_datastore u_la_datastore (
        .clk           (clk),
        .rstn          (rstn),
        .start         (start),
        .trig          (trig),
        .cfg           (cap_cfg),
        .word          (word),
        .armed         (armed),
        .trig_arm      (trig_arm),
        .busy          (busy),
        .done          (done),
        .overflow      (overflow),
        .rd_data_ready (rd_data_ready),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data)
    );

endmodule

// ==== verif/la_tb.sv ====
`timescale 1ns/1ps
`include "la_consts.svh"

module la_tb;
    import la_pkg::*;

    localparam int        HALF_PERIOD = 4;
    localparam bit [31:0] SEED        = 32'ha391e072;
    localparam count_t    DEPTH       = count_t'(1 << `LA_FIFO_AW);
    // 100 cycles to each of five triggers plus 12 cycles a word and one long stall
    localparam int        TIMEOUT_CYCLES = 5 * 100 + 12 * 156 + (4 * 80 + 16) + 500;

    logic         clk           = 1'b0;
    logic         rstn          = 1'b0;
    sample_t      digital_in    = '0;
    trig_cfg_t    trig_cfg      = '0;
    capture_cfg_t cap_cfg       = '0;
    logic         start         = 1'b0;
    logic         rd_data_valid = 1'b0;
    logic         busy;
    logic         done;
    logic         overflow;
    logic         rd_data_ready;
    word_t        rd_data;
    int           errors        = 0;
    int           cycle_cnt     = 0;

    la_top la_top_inst (.*);

    always #HALF_PERIOD clk = ~clk;
    always @(negedge clk) digital_in <= digital_in + 8'd1;  // free-running sample counter

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    // --------------------------------------------------
    // one capture from start to done
    // --------------------------------------------------
    // mode 0 reads freely, 1 pauses at random, 2 stalls until the FIFO must have overflowed
    task automatic run_capture(input count_t pre, input count_t total, input sample_t mask,
                               input sample_t noise, input sample_t offset, input int mode,
                               input count_t exp_words, input logic exp_ovf);
        word_t   words[$];
        word_t   held;
        sample_t tv;
        sample_t b;
        logic    pending;
        logic    trig_seen;
        logic    valid;
        logic    took_word;
        int      stall;
        int      k;
        @(negedge clk);
        tv                  = (digital_in + offset) & mask;  // first value the trigger accepts
        trig_cfg.mask       = mask;
        trig_cfg.pattern    = tv | (noise & ~mask);
        cap_cfg.pre_words   = pre;
        cap_cfg.total_words = total;
        start               = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_bit("done", 1'b0, done);
        check_bit("overflow", 1'b0, overflow);
        pending   = 1'b0;
        trig_seen = 1'b0;
        took_word = 1'b0;
        held      = '0;
        stall     = (mode == 2) ? int'(4 * total) + 16 : 0;
        while (!done) begin
            // busy rises exactly one cycle after the trigger sample is seen here
            check_bit("busy", trig_seen, busy);
            if (digital_in == tv) trig_seen = 1'b1;
            if (pending) begin  // a word left waiting must stay on the port unchanged
                check_bit("rd_data_ready", 1'b1, rd_data_ready);
                check_word("rd_data", held, rd_data);
            end
            if (stall > 0) begin
                valid = 1'b0;
                if (busy) stall--;
            end else if (mode == 1) begin
                valid = ($urandom % 4) != 0;
            end else begin
                valid = 1'b1;
            end
            rd_data_valid = valid;
            took_word     = rd_data_ready && valid;
            if (took_word) words.push_back(rd_data);
            pending = rd_data_ready && !valid;
            held    = rd_data;
            @(negedge clk);
        end
        rd_data_valid = 1'b0;
        check_count("word count", exp_words, count_t'(words.size()));
        check_bit("busy", 1'b0, busy);
        check_bit("rd_data_ready", 1'b0, rd_data_ready);
        check_bit("overflow", exp_ovf, overflow);
        if (!exp_ovf) begin
            // done follows the last read on the very next cycle
            check_bit("read handshake in the cycle before done", 1'b1, took_word);
        end
        for (k = 0; k < words.size(); k++) begin
            b = words[0][31:24] + sample_t'(4 * k);  // every word continues the count
            check_word("rd_data", {b, b + 8'd1, b + 8'd2, b + 8'd3}, words[k]);
        end
        if (words.size() > 0) begin
            b = tv - words[0][31:24];
            check_bit("trigger word index in pre_words-1 or pre_words", 1'b1,
                      ((count_t'(b) >> 2) == pre - 1) || ((count_t'(b) >> 2) == pre));
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_reset_state();
        check_bit("busy", 1'b0, busy);
        check_bit("done", 1'b0, done);
        check_bit("overflow", 1'b0, overflow);
        check_bit("rd_data_ready", 1'b0, rd_data_ready);
    endtask
    task automatic test_pretrigger();
        run_capture(4, 12, 8'hff, 8'h00, 8'd40, 0, 12, 1'b0);
    endtask
    task automatic test_masked_trigger();
        run_capture(4, 12, 8'hf0, 8'h09, 8'd56, 0, 12, 1'b0);  // low nibble of the pattern is noise
    endtask
    task automatic test_backpressure();
        run_capture(3, 40, 8'hff, 8'h00, 8'd36, 1, 40, 1'b0);
    endtask
    task automatic test_overflow();
        run_capture(4, 80, 8'hff, 8'h00, 8'd40, 2, DEPTH, 1'b1);
    endtask
    task automatic test_restart();
        run_capture(4, 12, 8'hff, 8'h00, 8'd40, 0, 12, 1'b0);
    endtask

    initial begin
        void'($urandom(SEED));
        repeat (4) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        test_reset_state();
        test_pretrigger();
        test_masked_trigger();
        test_backpressure();
        test_overflow();
        test_restart();
        $display("run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles with the tests unfinished, %0d errors",
                 cycle_cnt, errors);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/la_pkg.sv
rtl/la_fifo.sv
rtl/la_trigger.sv
rtl/la_sample_packer.sv
rtl/la_datastore.sv
rtl/la_top.sv
verif/la_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f project.f --top-module la_tb -o la_tb_sim
out=$(./obj_dir/la_tb_sim)
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED"
